/* verification/uart_stimulus.txt */
# loopback UART stimulus
# first value: bytes received before the mid-message reset (decimal)
# then: the expected message bytes in order, one hex byte per line

5

# greeting "Hello, World!!\r\n"
48
65
6C
6C
6F
2C
20
57
6F
72
6C
64
21
21
0D
0A

/* all.f */
src/uart_pkg.sv
src/uart_hello.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_top.sv
verification/uart_top_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the loopback UART testbench with Verilator and runs it

set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
  --top-module uart_top_tb -f all.f -o uart_sim

# the log decides the result, so the exit status of the simulator is not used here
./obj_dir/uart_sim | tee sim.log

if grep -q "All tests passed" sim.log; then
  echo "simulation PASSED"
  exit 0
else
  echo "simulation FAILED, see sim.log"
  exit 1
fi

/* verification/uart_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_top_tb;

  localparam int cycles_per_bit = 3;
  localparam int msg_len = uart_pkg::msg_len;
  localparam int frame_cycles = 10 * cycles_per_bit;
  // three passes of the message, each byte budgeted generously, then doubled
  localparam int watchdog_cycles = 3 * msg_len * (frame_cycles + 6) * 2;
  localparam string stim_path = "verification/uart_stimulus.txt";

  logic            clock;
  logic            i_rst_n;
  uart_pkg::data_t o_data;
  logic            o_valid;
  logic            o_done;
  uart_pkg::sum_t  o_sum;

  uart_pkg::data_t expected [msg_len];
  int              restart_count;
  uart_pkg::sum_t  running_sum;  // model of o_sum since the last reset
  int              pulse_count;  // o_valid pulses since the last reset

  uart_top #(
    .cycles_per_bit (cycles_per_bit)
  ) dut (
    .clock   (clock),
    .i_rst_n (i_rst_n),
    .o_data  (o_data),
    .o_valid (o_valid),
    .o_done  (o_done),
    .o_sum   (o_sum)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // independent count of receive pulses, restarted by every reset
  always @(negedge clock) begin
    if (!i_rst_n) pulse_count <= 0;
    else if (o_valid) pulse_count <= pulse_count + 1;
  end

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("timeout: the message never completed within %0d cycles", watchdog_cycles);
    abort_run();
  end

  task automatic check_data(input string name, input uart_pkg::data_t exp,
                            input uart_pkg::data_t act);
    if (act !== exp) begin
      $display("[ERROR] time %0t: %s expected 0x%02h, got 0x%02h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_sum(input string name, input uart_pkg::sum_t exp,
                           input uart_pkg::sum_t act);
    if (act !== exp) begin
      $display("[ERROR] time %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] time %0t: %s expected %b, got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  // lines starting with # are comments, the first value is decimal, bytes are hex
  task automatic read_stimulus();
    int    fd;
    int    found;
    int    n;
    int    value;
    string line;
    fd = $fopen(stim_path, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", stim_path);
      abort_run();
    end
    found = 0;
    while (found <= msg_len) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() == 0) continue;
      if (line[0] == "#") continue;
      if (found == 0) n = $sscanf(line, "%d", value);
      else n = $sscanf(line, "%h", value);
      if (n != 1) continue;  // blank line
      if (found == 0) restart_count = value;
      else expected[found-1] = uart_pkg::data_t'(value);
      found++;
    end
    $fclose(fd);
    if (found < msg_len + 1) begin
      $display("the stimulus file holds only %0d of %0d values", found, msg_len + 1);
      abort_run();
    end
    if (restart_count < 1 || restart_count >= msg_len) begin
      $display("the restart count %0d must lie between 1 and %0d", restart_count, msg_len - 1);
      abort_run();
    end
  endtask

  // reset is held across two rising edges, driven just after the edge
  task automatic pulse_reset();
    @(posedge clock);
    #5 i_rst_n = 1'b0;
    repeat (2) @(posedge clock);
    #5 i_rst_n = 1'b1;
    running_sum = '0;
  endtask

  task automatic check_reset_state();
    repeat (2) begin
      @(negedge clock);
      check_flag("o_valid", 1'b0, o_valid);
      check_flag("o_done", 1'b0, o_done);
      check_sum("o_sum", '0, o_sum);
      check_data("o_data", '0, o_data);
    end
  endtask

  // wait for the next receive pulse, done must stay low while bytes remain
  task automatic wait_valid();
    @(negedge clock);
    while (!o_valid) begin
      check_flag("o_done", 1'b0, o_done);
      @(negedge clock);
    end
  endtask

  task automatic receive_bytes(input int count);
    for (int i = 0; i < count; i++) begin
      wait_valid();
      check_data("o_data", expected[i], o_data);
      running_sum = running_sum + uart_pkg::sum_t'(expected[i]);
      check_sum("o_sum", running_sum, o_sum);
      if (i < msg_len - 1) check_flag("o_done", 1'b0, o_done);  // the last byte and done can land together
    end
  endtask

  task automatic wait_done();
    while (!o_done) begin
      @(negedge clock);
      check_flag("o_valid", 1'b0, o_valid);
    end
  endtask

  task automatic check_quiet_window();
    repeat (2 * frame_cycles) begin
      @(negedge clock);
      check_flag("o_valid", 1'b0, o_valid);
      check_flag("o_done", 1'b1, o_done);
    end
  endtask

  initial begin
    uart_pkg::sum_t total;
    i_rst_n = 1'b0;
    running_sum = '0;
    total = '0;
    read_stimulus();

    repeat (2) @(posedge clock);
    #5 i_rst_n = 1'b1;
    check_reset_state();

    // part of the message, then a reset in the middle of it
    receive_bytes(restart_count);
    pulse_reset();
    check_reset_state();

    // whole message from the first byte again
    receive_bytes(msg_len);
    wait_done();
    check_quiet_window();

    for (int i = 0; i < msg_len; i++) begin
      total = total + uart_pkg::sum_t'(expected[i]);
    end
    check_sum("o_sum", total, o_sum);

    if (pulse_count == msg_len) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("saw %0d receive pulses after the last reset, wanted %0d", pulse_count, msg_len);
      abort_run();
    end
  end

endmodule

`default_nettype wire

/* src/uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
  parameter int cycles_per_bit = 3
) (
  input  logic            clock,
  input  logic            i_rst_n,
  output uart_pkg::data_t o_data,
  output logic            o_valid,
  output logic            o_done,
  output uart_pkg::sum_t  o_sum
);

  uart_pkg::data_t hello_data;
  logic            hello_req;
  logic            hello_done;
  logic            tx_cts;
  logic            tx_idle;
  logic            tx_serial;  // looped straight back into the receiver
  logic            rx_valid;
  uart_pkg::data_t rx_data;
  uart_pkg::sum_t  rx_sum;

  uart_hello hello (
    .clock   (clock),
    .i_rst_n (i_rst_n),
    .i_cts   (tx_cts),
    .i_idle  (tx_idle),
    .o_data  (hello_data),
    .o_req   (hello_req),
    .o_done  (hello_done)
  );

  uart_tx #(
    .cycles_per_bit (cycles_per_bit)
  ) tx (
    .clock    (clock),
    .i_rst_n  (i_rst_n),
    .i_data   (hello_data),
    .i_req    (hello_req),
    .o_serial (tx_serial),
    .o_cts    (tx_cts),
    .o_idle   (tx_idle)
  );

  uart_rx #(
    .cycles_per_bit (cycles_per_bit)
  ) rx (
    .clock    (clock),
    .i_rst_n  (i_rst_n),
    .i_serial (tx_serial),
    .o_valid  (rx_valid),
    .o_buffer (rx_data),
    .o_sum    (rx_sum)
  );

  assign o_data  = rx_data;
  assign o_valid = rx_valid;
  assign o_sum   = rx_sum;

  // the sender finishing is not enough, the last frame must also leave the line
  assign o_done = hello_done && tx_idle;

endmodule

`default_nettype wire

/* src/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
  parameter int cycles_per_bit = 3
) (
  input  logic            clock,
  input  logic            i_rst_n,
  input  logic            i_serial,
  output logic            o_valid,
  output uart_pkg::data_t o_buffer,
  output uart_pkg::sum_t  o_sum
);

  localparam int cnt_w = $clog2(cycles_per_bit);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(cycles_per_bit - 1);
  // clocks from the detected edge to the middle of the start bit
  localparam logic [cnt_w-1:0] half_last = cnt_w'(cycles_per_bit / 2 - 1);

  uart_pkg::rx_phase_e phase;
  logic                line_meta;
  logic                line_sync;
  logic [cnt_w-1:0]    cnt;
  logic [2:0]          bit_idx;
  uart_pkg::data_t     shift;
  logic                sample;

  // two flops before the line is looked at
  always_ff @(posedge clock) begin
    if (!i_rst_n) begin
      line_meta <= 1'b1;
      line_sync <= 1'b1;
    end else begin
      line_meta <= i_serial;
      line_sync <= line_meta;
    end
  end

  assign sample = (phase == uart_pkg::RX_DATA) && (cnt == cnt_last);

  always_ff @(posedge clock) begin
    if (!i_rst_n) begin
      phase    <= uart_pkg::RX_IDLE;
      cnt      <= '0;
      bit_idx  <= '0;
      o_valid  <= 1'b0;
      o_buffer <= '0;
      o_sum    <= '0;
    end else begin
      o_valid <= 1'b0;
      case (phase)
        uart_pkg::RX_IDLE: begin
          cnt     <= '0;
          bit_idx <= '0;
          if (!line_sync) phase <= uart_pkg::RX_START;
        end
        uart_pkg::RX_START: begin
          // start bit checked at its middle, a short low is a glitch
          if (cnt == half_last) begin
            cnt   <= '0;
            phase <= line_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        uart_pkg::RX_DATA: begin
          cnt <= (cnt == cnt_last) ? '0 : cnt + 1'b1;
          if (sample) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) phase <= uart_pkg::RX_STOP;
          end
        end
        uart_pkg::RX_STOP: begin
          if (cnt == cnt_last) begin
            // middle of the stop bit, the byte is complete
            cnt      <= '0;
            phase    <= uart_pkg::RX_IDLE;
            o_valid  <= 1'b1;
            o_buffer <= shift;
            o_sum    <= o_sum + uart_pkg::sum_t'(shift);
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: phase <= uart_pkg::RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (sample) shift <= {line_sync, shift[7:1]};  // LSB arrives first
  end

endmodule

`default_nettype wire

/* src/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int cycles_per_bit = 3
) (
  input  logic            clock,
  input  logic            i_rst_n,
  input  uart_pkg::data_t i_data,
  input  logic            i_req,
  output logic            o_serial,
  output logic            o_cts,
  output logic            o_idle
);

  localparam int cnt_w = $clog2(cycles_per_bit);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(cycles_per_bit - 1);

  uart_pkg::tx_phase_e phase;
  logic [cnt_w-1:0]    cnt;      // clocks spent in the current bit
  logic [2:0]          bit_idx;  // data bit being driven
  uart_pkg::data_t     shift;
  logic                bit_end;
  logic                capture;

  assign bit_end = (cnt == cnt_last);
  assign capture = (phase == uart_pkg::TX_IDLE) && i_req;

  always_ff @(posedge clock) begin
    if (!i_rst_n) begin
      phase   <= uart_pkg::TX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
    end else begin
      case (phase)
        uart_pkg::TX_IDLE: begin
          cnt     <= '0;
          bit_idx <= '0;
          if (i_req) phase <= uart_pkg::TX_START;
        end
        uart_pkg::TX_START: begin
          cnt <= bit_end ? '0 : cnt + 1'b1;
          if (bit_end) phase <= uart_pkg::TX_DATA;
        end
        uart_pkg::TX_DATA: begin
          cnt <= bit_end ? '0 : cnt + 1'b1;
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) phase <= uart_pkg::TX_STOP;
          end
        end
        uart_pkg::TX_STOP: begin
          cnt <= bit_end ? '0 : cnt + 1'b1;
          if (bit_end) phase <= uart_pkg::TX_IDLE;  // cts back on the next cycle
        end
        default: phase <= uart_pkg::TX_IDLE;
      endcase
    end
  end

  // data goes out LSB first, so shift right after each data bit
  always_ff @(posedge clock) begin
    if (capture) begin
      shift <= i_data;
    end else if (phase == uart_pkg::TX_DATA && bit_end) begin
      shift <= shift >> 1;
    end
  end

  always_comb begin
    case (phase)
      uart_pkg::TX_START: o_serial = 1'b0;
      uart_pkg::TX_DATA:  o_serial = shift[0];
      default:            o_serial = 1'b1;  // stop bit and idle line are high
    endcase
  end

  // the byte is latched on the request edge, so idle and cts coincide
  assign o_cts  = (phase == uart_pkg::TX_IDLE);
  assign o_idle = (phase == uart_pkg::TX_IDLE);

endmodule

`default_nettype wire

/* src/uart_hello.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_hello (
  input  logic            clock,
  input  logic            i_rst_n,
  input  logic            i_cts,
  input  logic            i_idle,
  output uart_pkg::data_t o_data,
  output logic            o_req,
  output logic            o_done
);

  localparam int idx_w = $clog2(uart_pkg::msg_len);
  localparam logic [idx_w-1:0] last_idx = idx_w'(uart_pkg::msg_len - 1);

  uart_pkg::hello_state_e state;
  logic [idx_w-1:0]       cursor;  // ROM index of the next byte to send
  logic                   issue;

  // greeting text "Hello, World!!\r\n"
  function automatic uart_pkg::data_t rom_byte(input logic [idx_w-1:0] idx);
    case (idx)
      4'd0:    rom_byte = 8'h48;
      4'd1:    rom_byte = 8'h65;
      4'd2:    rom_byte = 8'h6C;
      4'd3:    rom_byte = 8'h6C;
      4'd4:    rom_byte = 8'h6F;
      4'd5:    rom_byte = 8'h2C;
      4'd6:    rom_byte = 8'h20;
      4'd7:    rom_byte = 8'h57;
      4'd8:    rom_byte = 8'h6F;
      4'd9:    rom_byte = 8'h72;
      4'd10:   rom_byte = 8'h6C;
      4'd11:   rom_byte = 8'h64;
      4'd12:   rom_byte = 8'h21;
      4'd13:   rom_byte = 8'h21;
      4'd14:   rom_byte = 8'h0D;
      4'd15:   rom_byte = 8'h0A;
      default: rom_byte = 8'h00;
    endcase
  endfunction

  // the transmitter only drops cts one cycle after it captures, so a request
  // still in flight must not be followed by another one
  assign issue = (state == uart_pkg::HELLO_SEND) && i_cts && !o_req;

  always_ff @(posedge clock) begin
    if (!i_rst_n) begin
      state  <= uart_pkg::HELLO_SEND;
      cursor <= '0;
      o_req  <= 1'b0;
    end else begin
      o_req <= issue;  // one-cycle pulse
      case (state)
        uart_pkg::HELLO_SEND: begin
          if (issue) begin
            cursor <= cursor + 1'b1;
            if (cursor == last_idx) state <= uart_pkg::HELLO_FLUSH;
          end
        end
        uart_pkg::HELLO_FLUSH: begin
          // idle is still high while the last request is pending, so wait it out
          if (!o_req && i_idle) state <= uart_pkg::HELLO_DONE;
        end
        uart_pkg::HELLO_DONE: begin
          state <= uart_pkg::HELLO_DONE;  // hold until reset
        end
        default: state <= uart_pkg::HELLO_SEND;
      endcase
    end
  end

  // byte travels alongside its request
  always_ff @(posedge clock) begin
    if (issue) o_data <= rom_byte(cursor);
  end

  assign o_done = (state == uart_pkg::HELLO_DONE);

endmodule

`default_nettype wire

/* src/uart_pkg.sv */
`default_nettype none

package uart_pkg;

  // one serial data byte
  typedef logic [7:0] data_t;

  // running byte checksum, wraps at 32 bits
  typedef logic [31:0] sum_t;

  // bytes in the greeting held by the sender ROM
  parameter int msg_len = 16;

  typedef enum logic [1:0] {
    HELLO_SEND,   // bytes remain to be handed off
    HELLO_FLUSH,  // last byte handed off, waiting for the line to go quiet
    HELLO_DONE
  } hello_state_e;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_phase_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_phase_e;

endpackage

`default_nettype wire
